// File: rtl/spy_pkg.sv
// shared constants and the command character type for the spy link
// TICKS_PER_OVS is sized for simulation; a real build sets it to
// clk / (16 * baud). Widths below assume four nibbles per data word.
`default_nettype none

package spy_pkg;

   localparam int DATA_W = 16;
   localparam int ADDR_W = 4;

   // clk cycles per oversample tick, oversample ticks per bit
   localparam int TICKS_PER_OVS = 4;
   localparam int OVS_RATE = 16;

   // command opcodes, upper nibble of a received character
   localparam logic [3:0] OP_SET_D3 = 4'h3;
   localparam logic [3:0] OP_SET_D2 = 4'h4;
   localparam logic [3:0] OP_SET_D1 = 4'h5;
   localparam logic [3:0] OP_SET_D0 = 4'h6;
   localparam logic [3:0] OP_READ = 4'h8;
   localparam logic [3:0] OP_WRITE = 4'h9;

   typedef struct packed {
      logic [3:0] op;
      logic [3:0] arg;
   } spy_cmd_t;

   // same eight bits, seen as a line byte or as op/arg
   typedef union packed {
      logic [7:0] raw;
      spy_cmd_t cmd;
   } spy_char_t;

endpackage

`default_nettype wire

// File: rtl/baud_tick_gen.sv
// oversample and bit tick enables derived from clk
// needs TICKS_PER_OVS >= 2 and OVS_RATE >= 2
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen (
   input wire clk,
   input wire reset,
   output logic ovs_tick,
   output logic bit_tick
);

   logic [$clog2(spy_pkg::TICKS_PER_OVS)-1:0] div_cnt;
   logic [$clog2(spy_pkg::OVS_RATE)-1:0] ovs_cnt;
   logic div_wrap;
   logic ovs_wrap;

   assign div_wrap = (int'(div_cnt) == spy_pkg::TICKS_PER_OVS - 1);
   assign ovs_wrap = (int'(ovs_cnt) == spy_pkg::OVS_RATE - 1);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         div_cnt <= '0;
         ovs_cnt <= '0;
         ovs_tick <= 1'b0;
         bit_tick <= 1'b0;
      end
      else
      begin
         ovs_tick <= div_wrap;
         // bit tick lines up with every OVS_RATE-th oversample tick
         bit_tick <= div_wrap && ovs_wrap;
         if (div_wrap)
         begin
            div_cnt <= '0;
            ovs_cnt <= ovs_wrap ? '0 : ovs_cnt + 1'b1;
         end
         else
         begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
// 8N1 receiver on the oversample tick, no parity
// one character of holding; a character that completes while it is full
// is dropped and flags overrun. Both error flags stay set until reset.
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input wire clk,
   input wire reset,
   input wire ovs_tick,
   input wire rs232_rxd,
   output logic rx_valid,
   output spy_pkg::spy_char_t rx_char,
   input wire rx_ready,
   output logic rx_frame_err,
   output logic rx_overrun
);

   logic rxd_meta;
   logic rxd_sync;
   logic busy;
   logic [$clog2(spy_pkg::OVS_RATE)-1:0] ovs_cnt;
   logic [3:0] bit_idx;
   logic [7:0] shifter;
   logic at_sample;
   logic sample;
   logic stop_ok;
   logic full;
   logic load;

   // start bit is checked at half a bit, everything else a full bit later
   assign at_sample = (bit_idx == 4'd0) ?
                      (int'(ovs_cnt) == spy_pkg::OVS_RATE / 2 - 1) :
                      (int'(ovs_cnt) == spy_pkg::OVS_RATE - 1);
   assign sample = ovs_tick && busy && at_sample;
   assign stop_ok = sample && (bit_idx == 4'd9) && rxd_sync;
   assign full = rx_valid && !rx_ready;
   assign load = stop_ok && !full;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end
      else
      begin
         rxd_meta <= rs232_rxd;
         rxd_sync <= rxd_meta;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         ovs_cnt <= '0;
         bit_idx <= 4'd0;
         rx_valid <= 1'b0;
         rx_frame_err <= 1'b0;
         rx_overrun <= 1'b0;
      end
      else
      begin
         if (rx_valid && rx_ready)
            rx_valid <= 1'b0;
         if (load)
            rx_valid <= 1'b1;
         if (stop_ok && full)
            rx_overrun <= 1'b1;
         if (sample && (bit_idx == 4'd9) && !rxd_sync)
            rx_frame_err <= 1'b1;

         if (ovs_tick && !busy)
         begin
            // falling edge on an idle line
            if (!rxd_sync)
            begin
               busy <= 1'b1;
               ovs_cnt <= '0;
               bit_idx <= 4'd0;
            end
         end
         else if (ovs_tick && !at_sample)
         begin
            ovs_cnt <= ovs_cnt + 1'b1;
         end
         else if (sample)
         begin
            ovs_cnt <= '0;
            bit_idx <= bit_idx + 4'd1;
            // glitch rather than a start bit, or the frame is done
            if ((bit_idx == 4'd0 && rxd_sync) || bit_idx == 4'd9)
               busy <= 1'b0;
         end
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk)
   begin
      if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8)
         shifter <= {rxd_sync, shifter[7:1]};
      if (load)
         rx_char.raw <= shifter;
   end

   a_rx_hold : assert property (@(posedge clk) disable iff (reset)
      rx_valid && !rx_ready |=> rx_valid && $stable(rx_char));

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
// 8N1 transmitter, one bit per bit_tick
// accepts a character only while idle; the start bit goes out on the
// bit tick after the transfer
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input wire clk,
   input wire reset,
   input wire bit_tick,
   input wire tx_valid,
   input spy_pkg::spy_char_t tx_char,
   output logic tx_ready,
   output logic rs232_txd
);

   logic busy;
   logic [3:0] bit_cnt;
   logic [9:0] shifter;

   assign tx_ready = !busy;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         bit_cnt <= 4'd0;
         rs232_txd <= 1'b1;
      end
      else if (tx_valid && tx_ready)
      begin
         busy <= 1'b1;
         bit_cnt <= 4'd0;
      end
      else if (busy && bit_tick)
      begin
         // ten bits out, then one more tick so the stop bit lasts a full bit
         if (bit_cnt == 4'd10)
         begin
            busy <= 1'b0;
         end
         else
         begin
            rs232_txd <= shifter[0];
            bit_cnt <= bit_cnt + 4'd1;
         end
      end
   end

   // stop, data, start; shifted out from bit 0
   always_ff @(posedge clk)
   begin
      if (tx_valid && tx_ready)
         shifter <= {1'b1, tx_char.raw, 1'b0};
      else if (busy && bit_tick)
         shifter <= {1'b1, shifter[9:1]};
   end

endmodule

`default_nettype wire

// File: rtl/spy_cmd_engine.sv
// command decoder for the serial spy port
// one command at a time; no new character is taken while a request
// is open or a reply is going out
`timescale 1ns/1ps
`default_nettype none

module spy_cmd_engine (
   input wire clk,
   input wire reset,
   input wire rx_valid,
   input spy_pkg::spy_char_t rx_char,
   output logic rx_ready,
   output logic tx_valid,
   output spy_pkg::spy_char_t tx_char,
   input wire tx_ready,
   output logic eng_valid,
   input wire eng_ready,
   output logic eng_we,
   output logic [spy_pkg::ADDR_W-1:0] eng_addr,
   output logic [spy_pkg::DATA_W-1:0] eng_wdata,
   input wire eng_rvalid,
   input wire [spy_pkg::DATA_W-1:0] eng_rdata
);

   logic rd_wait;
   logic replying;
   logic [1:0] tx_idx;
   logic take;
   logic is_bus_op;
   logic [spy_pkg::DATA_W-1:0] data_buf;
   logic [spy_pkg::DATA_W-1:0] resp;

   assign rx_ready = !(eng_valid || rd_wait || replying);
   assign take = rx_valid && rx_ready;
   assign is_bus_op = (rx_char.cmd.op == spy_pkg::OP_READ) ||
                      (rx_char.cmd.op == spy_pkg::OP_WRITE);
   assign tx_valid = replying;
   assign eng_wdata = data_buf;

   // idle, request, read wait, reply
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         eng_valid <= 1'b0;
         rd_wait <= 1'b0;
         replying <= 1'b0;
         tx_idx <= 2'd0;
      end
      else
      begin
         if (take && is_bus_op)
            eng_valid <= 1'b1;
         else if (eng_valid && eng_ready)
            eng_valid <= 1'b0;

         if (eng_valid && eng_ready && !eng_we)
            rd_wait <= 1'b1;
         else if (eng_rvalid)
            rd_wait <= 1'b0;

         if (rd_wait && eng_rvalid)
         begin
            replying <= 1'b1;
            tx_idx <= 2'd0;
         end
         else if (tx_valid && tx_ready)
         begin
            tx_idx <= tx_idx + 2'd1;
            if (tx_idx == 2'd3)
               replying <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         data_buf <= '0;
      else if (take)
      begin
         case (rx_char.cmd.op)
            spy_pkg::OP_SET_D3: data_buf[15:12] <= rx_char.cmd.arg;
            spy_pkg::OP_SET_D2: data_buf[11:8] <= rx_char.cmd.arg;
            spy_pkg::OP_SET_D1: data_buf[7:4] <= rx_char.cmd.arg;
            spy_pkg::OP_SET_D0: data_buf[3:0] <= rx_char.cmd.arg;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (take && is_bus_op)
      begin
         eng_we <= (rx_char.cmd.op == spy_pkg::OP_WRITE);
         eng_addr <= rx_char.cmd.arg;
      end
      if (rd_wait && eng_rvalid)
         resp <= eng_rdata;
   end

   // reply tags run 3..6, same codes as the nibble loads, high nibble first
   always_comb
   begin
      tx_char.cmd.op = spy_pkg::OP_SET_D3 + {2'b00, tx_idx};
      tx_char.cmd.arg = resp[4 * (3 - tx_idx) +: 4];
   end

   a_eng_hold : assert property (@(posedge clk) disable iff (reset)
      eng_valid && !eng_ready |=>
      eng_valid && $stable({eng_we, eng_addr, eng_wdata}));

   a_tx_hold : assert property (@(posedge clk) disable iff (reset)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_char));

endmodule

`default_nettype wire

// File: rtl/reg_bus_arbiter.sv
// round-robin arbiter putting engine and host onto one register file port
// grant is combinational; read data comes back one cycle after the grant
`timescale 1ns/1ps
`default_nettype none

module reg_bus_arbiter (
   input wire clk,
   input wire reset,
   input wire eng_valid,
   output logic eng_ready,
   input wire eng_we,
   input wire [spy_pkg::ADDR_W-1:0] eng_addr,
   input wire [spy_pkg::DATA_W-1:0] eng_wdata,
   output logic eng_rvalid,
   output logic [spy_pkg::DATA_W-1:0] eng_rdata,
   input wire host_valid,
   output logic host_ready,
   input wire host_we,
   input wire [spy_pkg::ADDR_W-1:0] host_addr,
   input wire [spy_pkg::DATA_W-1:0] host_wdata,
   output logic host_rvalid,
   output logic [spy_pkg::DATA_W-1:0] host_rdata,
   output logic mem_en,
   output logic mem_we,
   output logic [spy_pkg::ADDR_W-1:0] mem_addr,
   output logic [spy_pkg::DATA_W-1:0] mem_wdata,
   input wire [spy_pkg::DATA_W-1:0] mem_rdata
);

   // set after an engine grant, so the host wins the next tie
   logic prio_host;

   assign eng_ready = eng_valid && (!host_valid || !prio_host);
   assign host_ready = host_valid && (!eng_valid || prio_host);

   assign mem_en = eng_ready || host_ready;
   assign mem_we = host_ready ? host_we : eng_we;
   assign mem_addr = host_ready ? host_addr : eng_addr;
   assign mem_wdata = host_ready ? host_wdata : eng_wdata;

   // read data only reaches the peer that asked for it
   assign eng_rdata = eng_rvalid ? mem_rdata : '0;
   assign host_rdata = host_rvalid ? mem_rdata : '0;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         prio_host <= 1'b0;
         eng_rvalid <= 1'b0;
         host_rvalid <= 1'b0;
      end
      else
      begin
         if (eng_ready)
            prio_host <= 1'b1;
         else if (host_ready)
            prio_host <= 1'b0;
         eng_rvalid <= eng_ready && !eng_we;
         host_rvalid <= host_ready && !host_we;
      end
   end

   // both peers asking twice in a row must see the grant swap
   a_rr_swap : assert property (@(posedge clk) disable iff (reset)
      eng_valid && host_valid |=>
      !(eng_valid && host_valid) || (eng_ready != $past(eng_ready)));

endmodule

`default_nettype wire

// File: rtl/spy_regfile.sv
// 16 x 16 register file, one access per cycle
// read data is registered and holds until the next read
`timescale 1ns/1ps
`default_nettype none

module spy_regfile (
   input wire clk,
   input wire reset,
   input wire mem_en,
   input wire mem_we,
   input wire [spy_pkg::ADDR_W-1:0] mem_addr,
   input wire [spy_pkg::DATA_W-1:0] mem_wdata,
   output logic [spy_pkg::DATA_W-1:0] mem_rdata
);

   logic [spy_pkg::DATA_W-1:0] regs [2**spy_pkg::ADDR_W];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < 2**spy_pkg::ADDR_W; i++)
            regs[i] <= '0;
      end
      else if (mem_en && mem_we)
      begin
         regs[mem_addr] <= mem_wdata;
      end
   end

   always_ff @(posedge clk)
   begin
      if (mem_en && !mem_we)
         mem_rdata <= regs[mem_addr];
   end

endmodule

`default_nettype wire

// File: rtl/spy_link_top.sv
// serial spy link, RS-232 command port plus a parallel host port
// everything runs on clk; only rs232_rxd is asynchronous
`timescale 1ns/1ps
`default_nettype none

module spy_link_top (
   input wire clk,
   input wire reset,
   input wire rs232_rxd,
   output logic rs232_txd,
   input wire host_valid,
   output logic host_ready,
   input wire host_we,
   input wire [spy_pkg::ADDR_W-1:0] host_addr,
   input wire [spy_pkg::DATA_W-1:0] host_wdata,
   output logic host_rvalid,
   output logic [spy_pkg::DATA_W-1:0] host_rdata,
   output logic rx_frame_err,
   output logic rx_overrun
);

   logic ovs_tick;
   logic bit_tick;
   logic rx_valid;
   logic rx_ready;
   spy_pkg::spy_char_t rx_char;
   logic tx_valid;
   logic tx_ready;
   spy_pkg::spy_char_t tx_char;
   logic eng_valid;
   logic eng_ready;
   logic eng_we;
   logic [spy_pkg::ADDR_W-1:0] eng_addr;
   logic [spy_pkg::DATA_W-1:0] eng_wdata;
   logic eng_rvalid;
   logic [spy_pkg::DATA_W-1:0] eng_rdata;
   logic mem_en;
   logic mem_we;
   logic [spy_pkg::ADDR_W-1:0] mem_addr;
   logic [spy_pkg::DATA_W-1:0] mem_wdata;
   logic [spy_pkg::DATA_W-1:0] mem_rdata;

   baud_tick_gen u_ticks (
      .clk(clk),
      .reset(reset),
      .ovs_tick(ovs_tick),
      .bit_tick(bit_tick)
   );

   uart_rx u_rx (
      .clk(clk),
      .reset(reset),
      .ovs_tick(ovs_tick),
      .rs232_rxd(rs232_rxd),
      .rx_valid(rx_valid),
      .rx_char(rx_char),
      .rx_ready(rx_ready),
      .rx_frame_err(rx_frame_err),
      .rx_overrun(rx_overrun)
   );

   uart_tx u_tx (
      .clk(clk),
      .reset(reset),
      .bit_tick(bit_tick),
      .tx_valid(tx_valid),
      .tx_char(tx_char),
      .tx_ready(tx_ready),
      .rs232_txd(rs232_txd)
   );

   spy_cmd_engine u_engine (
      .clk(clk),
      .reset(reset),
      .rx_valid(rx_valid),
      .rx_char(rx_char),
      .rx_ready(rx_ready),
      .tx_valid(tx_valid),
      .tx_char(tx_char),
      .tx_ready(tx_ready),
      .eng_valid(eng_valid),
      .eng_ready(eng_ready),
      .eng_we(eng_we),
      .eng_addr(eng_addr),
      .eng_wdata(eng_wdata),
      .eng_rvalid(eng_rvalid),
      .eng_rdata(eng_rdata)
   );

   reg_bus_arbiter u_arb (
      .clk(clk),
      .reset(reset),
      .eng_valid(eng_valid),
      .eng_ready(eng_ready),
      .eng_we(eng_we),
      .eng_addr(eng_addr),
      .eng_wdata(eng_wdata),
      .eng_rvalid(eng_rvalid),
      .eng_rdata(eng_rdata),
      .host_valid(host_valid),
      .host_ready(host_ready),
      .host_we(host_we),
      .host_addr(host_addr),
      .host_wdata(host_wdata),
      .host_rvalid(host_rvalid),
      .host_rdata(host_rdata),
      .mem_en(mem_en),
      .mem_we(mem_we),
      .mem_addr(mem_addr),
      .mem_wdata(mem_wdata),
      .mem_rdata(mem_rdata)
   );

   spy_regfile u_regs (
      .clk(clk),
      .reset(reset),
      .mem_en(mem_en),
      .mem_we(mem_we),
      .mem_addr(mem_addr),
      .mem_wdata(mem_wdata),
      .mem_rdata(mem_rdata)
   );

endmodule

`default_nettype wire

// File: bench/spy_link_tb.sv
// testbench for the serial spy link
// serial driver and reply decoder both run at 64 clk cycles per bit,
// which holds only for TICKS_PER_OVS = 4 and OVS_RATE = 16
`timescale 1ns/1ps
`default_nettype none

module spy_link_tb;

   localparam int BIT_CYCLES = 64;
   localparam int HOST_TIMEOUT = 64;
   localparam int REPLY_TIMEOUT = 2000;

   localparam logic [3:0] SET_D3 = 4'h3;
   localparam logic [3:0] SET_D2 = 4'h4;
   localparam logic [3:0] SET_D1 = 4'h5;
   localparam logic [3:0] SET_D0 = 4'h6;
   localparam logic [3:0] READ = 4'h8;
   localparam logic [3:0] WRITE = 4'h9;

   logic clk = 1'b0;
   logic reset = 1'b1;
   logic rs232_rxd;
   logic rs232_txd;
   logic host_valid;
   logic host_ready;
   logic host_we;
   logic [3:0] host_addr;
   logic [15:0] host_wdata;
   logic host_rvalid;
   logic [15:0] host_rdata;
   logic rx_frame_err;
   logic rx_overrun;

   int errors = 0;
   int checks = 0;
   int timeouts = 0;
   logic [31:0] lcg_state = 32'd33649;

   spy_link_top dut (
      .clk(clk),
      .reset(reset),
      .rs232_rxd(rs232_rxd),
      .rs232_txd(rs232_txd),
      .host_valid(host_valid),
      .host_ready(host_ready),
      .host_we(host_we),
      .host_addr(host_addr),
      .host_wdata(host_wdata),
      .host_rvalid(host_rvalid),
      .host_rdata(host_rdata),
      .rx_frame_err(rx_frame_err),
      .rx_overrun(rx_overrun)
   );

   always #5 clk = ~clk;

   // read data comes back exactly one cycle after an accepted host read
   a_rvalid_after_read : assert property (@(posedge clk) disable iff (reset)
      host_valid && host_ready && !host_we |=> host_rvalid)
   else
   begin
      errors++;
      $display("[ERROR] %0t host_rvalid expected 1 got 0", $time);
   end

   a_rvalid_only_for_read : assert property (@(posedge clk) disable iff (reset)
      host_rvalid |-> $past(host_valid && host_ready && !host_we))
   else
   begin
      errors++;
      $display("[ERROR] %0t host_rvalid expected 0 got 1", $time);
   end

   a_ready_needs_valid : assert property (@(posedge clk) disable iff (reset)
      host_ready |-> host_valid)
   else
   begin
      errors++;
      $display("[ERROR] %0t host_ready expected 0 got 1", $time);
   end

   // characters are spaced so the receiver never overruns
   a_no_overrun : assert property (@(posedge clk) disable iff (reset)
      !rx_overrun)
   else
   begin
      errors++;
      $display("[ERROR] %0t rx_overrun expected 0 got 1", $time);
   end

   function automatic logic [15:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[31:16];
   endfunction

   task automatic expect_equal(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
      checks++;
      assert (act === exp)
      else
      begin
         errors++;
         $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("timeout at %0t: %s", $time, what);
   endtask

   task automatic drive_bit(input logic b);
      rs232_rxd = b;
      repeat (BIT_CYCLES) @(negedge clk);
   endtask

   // start, eight data bits lsb first, stop
   task automatic send_char(input logic [7:0] c, input bit bad_stop);
      @(negedge clk);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++)
         drive_bit(c[i]);
      drive_bit(!bad_stop);
      rs232_rxd = 1'b1;
   endtask

   task automatic send_nibbles(input logic [15:0] value);
      send_char({SET_D3, value[15:12]}, 1'b0);
      send_char({SET_D2, value[11:8]}, 1'b0);
      send_char({SET_D1, value[7:4]}, 1'b0);
      send_char({SET_D0, value[3:0]}, 1'b0);
   endtask

   // samples rs232_txd in the middle of each bit
   task automatic receive_char(output logic [7:0] c);
      int n;
      c = 'x;
      n = 0;
      while (rs232_txd && n < REPLY_TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (rs232_txd)
         report_timeout("no start bit seen on rs232_txd");
      else
      begin
         repeat (BIT_CYCLES / 2) @(negedge clk);
         expect_equal("rs232_txd start bit", 16'd0, 16'(rs232_txd));
         for (int i = 0; i < 8; i++)
         begin
            repeat (BIT_CYCLES) @(negedge clk);
            c[i] = rs232_txd;
         end
         repeat (BIT_CYCLES) @(negedge clk);
         expect_equal("rs232_txd stop bit", 16'd1, 16'(rs232_txd));
      end
   endtask

   task automatic serial_read_check(input logic [3:0] addr, input logic [15:0] value);
      logic [7:0] reply [4];
      logic [3:0] tags [4];
      logic [3:0] nibs [4];
      bit extra;
      tags = '{SET_D3, SET_D2, SET_D1, SET_D0};
      nibs = '{value[15:12], value[11:8], value[7:4], value[3:0]};
      extra = 1'b0;
      fork
         send_char({READ, addr}, 1'b0);
         begin
            for (int k = 0; k < 4; k++)
               receive_char(reply[k]);
         end
      join
      for (int k = 0; k < 4; k++)
         expect_equal($sformatf("rs232_txd reply char %0d", k),
                      16'({tags[k], nibs[k]}), 16'(reply[k]));
      // the line stays idle after the fourth stop bit
      repeat (3 * BIT_CYCLES)
      begin
         @(negedge clk);
         if (!rs232_txd)
            extra = 1'b1;
      end
      checks++;
      assert (!extra)
      else
      begin
         errors++;
         $display("a fifth character was sent after the read reply at %0t", $time);
      end
   endtask

   task automatic host_access(input logic we, input logic [3:0] addr,
                              input logic [15:0] wdata, output logic [15:0] rdata);
      int n;
      bit done;
      rdata = 'x;
      @(negedge clk);
      host_valid = 1'b1;
      host_we = we;
      host_addr = addr;
      host_wdata = wdata;
      n = 0;
      done = 1'b0;
      while (!done && n < HOST_TIMEOUT)
      begin
         @(posedge clk);
         done = host_ready;
         n++;
      end
      @(negedge clk);
      host_valid = 1'b0;
      if (!done)
         report_timeout("host request was never accepted");
      else if (!we)
      begin
         n = 0;
         while (!host_rvalid && n < 4)
         begin
            @(negedge clk);
            n++;
         end
         if (!host_rvalid)
            report_timeout("host read data never came back");
         else
            rdata = host_rdata;
      end
   endtask

   task automatic host_write(input logic [3:0] addr, input logic [15:0] wdata);
      logic [15:0] unused;
      host_access(1'b1, addr, wdata, unused);
   endtask

   task automatic host_read(input logic [3:0] addr, output logic [15:0] rdata);
      host_access(1'b0, addr, 16'h0000, rdata);
   endtask

   initial
   begin
      logic [15:0] value;
      logic [15:0] junk;
      logic [15:0] rd;
      logic [15:0] old_v;
      logic [15:0] new_v;
      int n_reads;
      int after_done;
      bit line_done;
      bit seen_new;

      rs232_rxd = 1'b1;
      host_valid = 1'b0;
      host_we = 1'b0;
      host_addr = 4'h0;
      host_wdata = 16'h0000;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      // idle state after reset
      expect_equal("rs232_txd", 16'd1, 16'(rs232_txd));
      expect_equal("host_ready", 16'd0, 16'(host_ready));
      expect_equal("host_rvalid", 16'd0, 16'(host_rvalid));
      expect_equal("rx_frame_err", 16'd0, 16'(rx_frame_err));
      expect_equal("rx_overrun", 16'd0, 16'(rx_overrun));

      // serial nibble loads and a write checked by a host read
      value = lcg_next();
      send_nibbles(value);
      send_char({WRITE, 4'h5}, 1'b0);
      host_read(4'h5, rd);
      expect_equal("host_rdata reg 5", value, rd);

      // host write checked through a serial read reply
      value = lcg_next();
      host_write(4'hc, value);
      serial_read_check(4'hc, value);

      // ignored opcodes mixed into the loads
      value = lcg_next();
      junk = lcg_next();
      send_char({SET_D3, value[15:12]}, 1'b0);
      send_char({4'h0, junk[3:0]}, 1'b0);
      send_char({SET_D2, value[11:8]}, 1'b0);
      send_char({4'h7, junk[7:4]}, 1'b0);
      send_char({SET_D1, value[7:4]}, 1'b0);
      send_char({4'ha, junk[11:8]}, 1'b0);
      send_char({SET_D0, value[3:0]}, 1'b0);
      send_char({4'hf, junk[15:12]}, 1'b0);
      send_char({WRITE, 4'h3}, 1'b0);
      host_read(4'h3, rd);
      expect_equal("host_rdata reg 3", value, rd);

      // host reads racing a pending serial write
      old_v = lcg_next();
      new_v = ~old_v;
      host_write(4'h9, old_v);
      send_nibbles(new_v);
      line_done = 1'b0;
      seen_new = 1'b0;
      n_reads = 0;
      after_done = 0;
      fork
         begin
            send_char({WRITE, 4'h9}, 1'b0);
            line_done = 1'b1;
         end
         begin
            while (after_done < 8 && n_reads < 1000)
            begin
               host_read(4'h9, rd);
               n_reads++;
               if (line_done)
               begin
                  expect_equal("host_rdata after serial write", new_v, rd);
                  after_done++;
               end
               else
               begin
                  checks++;
                  assert ((rd === old_v && !seen_new) || rd === new_v)
                  else
                  begin
                     errors++;
                     $display("[ERROR] %0t host_rdata expected %h or %h got %h",
                              $time, old_v, new_v, rd);
                  end
                  if (rd === new_v)
                     seen_new = 1'b1;
               end
            end
         end
      join

      // write command with a bad stop bit is dropped
      value = ~new_v;
      host_write(4'he, value);
      send_char({WRITE, 4'he}, 1'b1);
      repeat (2 * BIT_CYCLES) @(negedge clk);
      expect_equal("rx_frame_err", 16'd1, 16'(rx_frame_err));
      host_read(4'he, rd);
      expect_equal("host_rdata reg e", value, rd);

      $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: spy_link.f
rtl/spy_pkg.sv
rtl/baud_tick_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/spy_cmd_engine.sv
rtl/reg_bus_arbiter.sv
rtl/spy_regfile.sv
rtl/spy_link_top.sv
bench/spy_link_tb.sv

// File: Bender.yml
package:
  name: spy_link

sources:
  - rtl/spy_pkg.sv
  - rtl/baud_tick_gen.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/spy_cmd_engine.sv
  - rtl/reg_bus_arbiter.sv
  - rtl/spy_regfile.sv
  - rtl/spy_link_top.sv
  - target: simulation
    files:
      - bench/spy_link_tb.sv
